// ==== ifetch_mmu_defs.svh ====
`ifndef IFETCH_MMU_DEFS_SVH
`define IFETCH_MMU_DEFS_SVH

// ----------------------------------------------------------------------
// Array sizes.
// ----------------------------------------------------------------------
`define IFM_CACHE_LINES       16      // Direct-mapped lines.
`define IFM_LINE_WORDS        4       // Words per line.
`define IFM_TLB_ENTRIES       8       // Section TLB entries.

// ----------------------------------------------------------------------
// First-level descriptor fields.
// ----------------------------------------------------------------------
`define IFM_DESC_SECTION      2'b10   // Type code in bits 1:0.
`define IFM_DESC_C_BIT        3       // Cacheable bit.

// Fault status codes.
`define IFM_FSR_SECTION_FAULT 4'h5    // Section translation fault.

`endif

// ==== ifetch_mmu_pkg.sv ====
`include "ifetch_mmu_defs.svh"

package ifetch_mmu_pkg;

        // ------------------------------------------------------------------
        // Address and data widths.
        // ------------------------------------------------------------------
        typedef logic [31:0]                    vaddr_t;      // Virtual address.
        typedef logic [31:0]                    paddr_t;      // Physical address.
        typedef logic [31:0]                    word_t;       // Instruction word.
        typedef logic [`IFM_LINE_WORDS*32-1:0]  line_t;       // One cache line.
        typedef logic [11:0]                    sect_base_t;  // PA bits 31:20.
        typedef logic [8:0]                     tlb_tag_t;    // VA bits 31:23.
        typedef logic [23:0]                    cache_tag_t;  // VA bits 31:8.

        // Section TLB entry, 22 bits.
        typedef struct packed {
                tlb_tag_t   tag;        // Upper VA bits above the index.
                sect_base_t base;       // Physical section number.
                logic       cacheable;  // C bit from the descriptor.
        } tlb_entry_t;

        // Cache entry, tag and data kept together. 152 bits.
        typedef struct packed {
                cache_tag_t tag;
                line_t      line;
        } cache_entry_t;

        // Read request to memory. 33 bits.
        typedef struct packed {
                paddr_t addr;
                logic   rd_en;
        } ram_req_t;

        // Result of the combined TLB and cache compare. 67 bits.
        typedef struct packed {
                logic   tlb_hit;
                logic   cache_hit;
                logic   cacheable;      // Only set with translation on.
                paddr_t paddr;          // Translated or passed through.
                word_t  word;           // Word picked from the cache line.
        } lookup_t;

        // Fetch FSM states.
        typedef enum logic [1:0] {
                S_IDLE,
                S_WALK,
                S_FILL,
                S_REFRESH
        } fetch_state_t;

endpackage

// ==== inv_mem.sv ====
`timescale 1ns/1ps

module inv_mem #(
        parameter  int DEPTH = 16,
        parameter  int WIDTH = 32,
        localparam int AW    = $clog2(DEPTH)
) (
        input  logic             i_clk,
        input  logic             i_reset,
        input  logic             i_inv,          // Drop every entry.
        input  logic             i_ren,          // Advance the read register.
        input  logic             i_refresh,      // Re-read at the write index.
        input  logic [AW-1:0]    i_raddr,        // Read index, next address.
        input  logic [AW-1:0]    i_waddr,        // Write index, current address.
        input  logic             i_wen,
        input  logic [WIDTH-1:0] i_wdata,
        output logic [WIDTH-1:0] o_rdata,        // Registered read data.
        output logic             o_rdav          // Registered valid bit.
);

        logic [WIDTH-1:0] mem [DEPTH];           // Storage array.
        logic [DEPTH-1:0] valid_q;               // One valid bit per entry.
        logic [AW-1:0]    rd_idx;

        // Refresh points the read port back at the current address.
        assign rd_idx = i_refresh ? i_waddr : i_raddr;

        // Array and read data.
        always_ff @(posedge i_clk)
        begin
                if (i_wen)
                        mem[i_waddr] <= i_wdata;
                if (i_ren || i_refresh)
                        o_rdata <= mem[rd_idx];
        end

        // ------------------------------------------------------------------
        // Valid bits. Invalidate wins over a write in the same cycle.
        // ------------------------------------------------------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_inv)
                begin
                        valid_q <= '0;
                        o_rdav  <= 1'b0;
                end
                else
                begin
                        if (i_wen)
                                valid_q[i_waddr] <= 1'b1;   // Fresh entry.
                        if (i_ren || i_refresh)
                                o_rdav <= valid_q[rd_idx];
                end
        end

        // The controller only refreshes while it stalls the pipe.
        a_refresh_no_ren: assert property (@(posedge i_clk) disable iff (i_reset)
                !(i_refresh && i_ren));

endmodule

// ==== fetch_lookup.sv ====
`timescale 1ns/1ps

module fetch_lookup
        import ifetch_mmu_pkg::*;
(
        input  vaddr_t       i_addr,         // Current fetch address.
        input  logic         i_mmu_en,
        input  tlb_entry_t   i_tlb_entry,    // TLB read register.
        input  logic         i_tlb_valid,
        input  cache_entry_t i_cache_entry,  // Cache read register.
        input  logic         i_cache_valid,
        output lookup_t      o_lookup
);

        tlb_tag_t   va_tlb_tag;
        cache_tag_t va_cache_tag;

        assign va_tlb_tag   = i_addr[31:23];
        assign va_cache_tag = i_addr[31:8];

        always_comb
        begin
                // TLB compare.
                o_lookup.tlb_hit = i_tlb_valid && (i_tlb_entry.tag == va_tlb_tag);

                // Section base plus offset, or flat with translation off.
                if (i_mmu_en)
                        o_lookup.paddr = {i_tlb_entry.base, i_addr[19:0]};
                else
                        o_lookup.paddr = i_addr;

                // No translation means no cacheable attribute.
                o_lookup.cacheable = i_mmu_en && i_tlb_entry.cacheable;

                // Virtual tag compare on the line.
                o_lookup.cache_hit = i_cache_valid &&
                                     (i_cache_entry.tag == va_cache_tag);

                // Word select within the line.
                o_lookup.word = i_cache_entry.line[i_addr[3:2]*32 +: 32];
        end

endmodule

// ==== fetch_ctrl.sv ====
`timescale 1ns/1ps
`include "ifetch_mmu_defs.svh"

module fetch_ctrl
        import ifetch_mmu_pkg::*;
(
        input  logic         i_clk,
        input  logic         i_reset,
        input  logic         i_stall,        // Core pipeline hold.
        input  logic         i_clear,        // Flush pulse.
        input  vaddr_t       i_addr,         // Current fetch address.
        input  logic         i_mmu_en,
        input  logic         i_cache_en,
        input  paddr_t       i_table_base,   // Translation table base.
        input  lookup_t      i_lookup,
        input  word_t        i_ram_rd_data,
        input  logic         i_ram_done,     // Read data valid this cycle.
        output ram_req_t     o_ram_req,
        output logic         o_tlb_wen,
        output tlb_entry_t   o_tlb_wdata,
        output logic         o_cache_wen,
        output cache_entry_t o_cache_wdata,
        output logic         o_refresh,      // Re-read both memories.
        output logic         o_stall,
        output logic         o_fault,
        output word_t        o_rd_data,
        output logic [3:0]   o_fsr,
        output vaddr_t       o_far
);

        localparam int CW = $clog2(`IFM_LINE_WORDS);

        fetch_state_t                    state_q, state_nxt;
        logic [CW-1:0]                   cnt_q;          // Linefill word counter.
        word_t [`IFM_LINE_WORDS-2:0]     buf_q;          // First words of a line.
        word_t                           rdata_q;        // Descriptor or held word.
        logic                            held_q;         // Bypass word parked.
        logic                            busy_q;         // Request in flight.
        logic                            req_want;
        paddr_t                          req_addr;
        logic                            byp_done;
        logic                            last_word;

        assign last_word = (cnt_q == CW'(`IFM_LINE_WORDS - 1));

        // ------------------------------------------------------------------
        // Next state and outputs.
        // ------------------------------------------------------------------
        always_comb
        begin
                state_nxt     = state_q;
                req_want      = 1'b0;
                req_addr      = i_lookup.paddr;
                byp_done      = 1'b0;
                o_stall       = 1'b1;
                o_fault       = 1'b0;
                o_rd_data     = i_ram_rd_data;
                o_refresh     = 1'b0;
                o_tlb_wen     = 1'b0;
                o_tlb_wdata   = '{tag:       i_addr[31:23],
                                  base:      rdata_q[31:20],
                                  cacheable: rdata_q[`IFM_DESC_C_BIT]};
                o_cache_wen   = 1'b0;
                o_cache_wdata = '{tag: i_addr[31:8], line: {i_ram_rd_data, buf_q}};

                case (state_q)
                S_IDLE:
                begin
                        if (held_q)
                        begin
                                o_stall   = 1'b0;       // Word parked under stall.
                                o_rd_data = rdata_q;
                        end
                        else if (i_mmu_en && !i_lookup.tlb_hit)
                        begin
                                // Table entry fetch.
                                req_want = 1'b1;
                                req_addr = {i_table_base[31:14], i_addr[31:20], 2'b00};
                                if (i_ram_done)
                                        state_nxt = S_WALK;
                        end
                        else if (i_lookup.cacheable && i_cache_en)
                        begin
                                o_rd_data = i_lookup.word;
                                o_stall   = !i_lookup.cache_hit;
                                if (!i_lookup.cache_hit)
                                        state_nxt = S_FILL;     // Linefill.
                        end
                        else
                        begin
                                // Uncached, completes here.
                                req_want = 1'b1;
                                o_stall  = !i_ram_done;
                                byp_done = i_ram_done;
                        end
                end

                S_WALK:
                begin
                        if (rdata_q[1:0] == `IFM_DESC_SECTION)
                        begin
                                o_tlb_wen = 1'b1;
                                state_nxt = S_REFRESH;
                        end
                        else
                        begin
                                o_fault   = 1'b1;       // Ends the fetch.
                                o_stall   = 1'b0;
                                state_nxt = S_IDLE;
                        end
                end

                S_FILL:
                begin
                        req_want = 1'b1;
                        req_addr = {i_lookup.paddr[31:4], cnt_q, 2'b00};
                        if (i_ram_done && last_word)
                        begin
                                o_cache_wen = 1'b1;     // Line and tag together.
                                state_nxt   = S_REFRESH;
                        end
                end

                default:
                begin
                        o_refresh = 1'b1;               // New entry visible next.
                        state_nxt = S_IDLE;
                end
                endcase

                // New requests wait for the core. One in flight is held.
                o_ram_req.addr  = req_addr;
                o_ram_req.rd_en = req_want && (!i_stall || busy_q);
        end

        // ------------------------------------------------------------------
        // Control registers.
        // ------------------------------------------------------------------
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        state_q <= S_IDLE;
                        cnt_q   <= '0;
                        held_q  <= 1'b0;
                        busy_q  <= 1'b0;
                        o_fsr   <= '0;
                        o_far   <= '0;
                end
                else
                begin
                        // A memory response always moves on, stall or not.
                        if (i_clear)
                                state_q <= S_IDLE;
                        else if (!i_stall || i_ram_done)
                                state_q <= state_nxt;

                        if (state_q != S_FILL || i_clear)
                                cnt_q <= '0;
                        else if (i_ram_done)
                                cnt_q <= cnt_q + 1'b1;  // Wraps on the last word.

                        held_q <= (held_q || byp_done) && i_stall && !i_clear;
                        busy_q <= o_ram_req.rd_en && !i_ram_done && !i_clear;

                        if (o_fault)
                        begin
                                o_fsr <= `IFM_FSR_SECTION_FAULT;
                                o_far <= i_addr;        // Faulting VA.
                        end
                end
        end

        // Data capture.
        always_ff @(posedge i_clk)
        begin
                if (state_q == S_IDLE && i_ram_done)
                        rdata_q <= i_ram_rd_data;
                if (state_q == S_FILL && i_ram_done && !last_word)
                        buf_q <= {i_ram_rd_data, buf_q[`IFM_LINE_WORDS-2:1]};
        end

        // ------------------------------------------------------------------
        // Checks.
        // ------------------------------------------------------------------
        a_one_write: assert property (@(posedge i_clk) disable iff (i_reset)
                !(o_tlb_wen && o_cache_wen));

        a_fault_done: assert property (@(posedge i_clk) disable iff (i_reset)
                !(o_fault && o_stall));

        // Request held steady until memory answers.
        a_req_stable: assert property (@(posedge i_clk) disable iff (i_reset)
                o_ram_req.rd_en && !i_ram_done && !i_clear
                |=> o_ram_req.rd_en && $stable(o_ram_req.addr));

endmodule

// ==== ifetch_mmu_top.sv ====
`timescale 1ns/1ps
`include "ifetch_mmu_defs.svh"

module ifetch_mmu_top
        import ifetch_mmu_pkg::*;
(
        input  logic       i_clk,
        input  logic       i_reset,
        // Core side.
        input  vaddr_t     i_addr_nxt,     // Next fetch, memory read index.
        input  vaddr_t     i_addr,         // Current fetch.
        input  logic       i_stall,
        input  logic       i_clear,
        // Control levels and pulses.
        input  logic       i_mmu_en,
        input  logic       i_cache_en,
        input  logic       i_tlb_inv,
        input  logic       i_cache_inv,
        input  paddr_t     i_table_base,
        // To the core.
        output word_t      o_rd_data,
        output logic       o_stall,
        output logic       o_fault,
        output logic [3:0] o_fsr,
        output vaddr_t     o_far,
        // Memory.
        output ram_req_t   o_ram_req,
        input  word_t      i_ram_rd_data,
        input  logic       i_ram_done
);

        tlb_entry_t   tlb_rdata, tlb_wdata;
        cache_entry_t cache_rdata, cache_wdata;
        logic         tlb_rdav, cache_rdav;
        logic         tlb_wen, cache_wen;
        logic         refresh;
        lookup_t      lookup;

        // ------------------------------------------------------------------
        // Section TLB. Indexed by VA 22:20.
        // ------------------------------------------------------------------
        inv_mem #(.DEPTH(`IFM_TLB_ENTRIES), .WIDTH($bits(tlb_entry_t))) u_tlb (
                .i_clk     (i_clk),
                .i_reset   (i_reset),
                .i_inv     (i_tlb_inv || !i_mmu_en),
                .i_ren     (!o_stall && !i_stall),
                .i_refresh (refresh),
                .i_raddr   (i_addr_nxt[22:20]),
                .i_waddr   (i_addr[22:20]),
                .i_wen     (tlb_wen),
                .i_wdata   (tlb_wdata),
                .o_rdata   (tlb_rdata),
                .o_rdav    (tlb_rdav)
        );

        // Line cache. Indexed by VA 7:4.
        inv_mem #(.DEPTH(`IFM_CACHE_LINES), .WIDTH($bits(cache_entry_t))) u_cache (
                .i_clk     (i_clk),
                .i_reset   (i_reset),
                .i_inv     (i_cache_inv || !i_cache_en),
                .i_ren     (!o_stall && !i_stall),
                .i_refresh (refresh),
                .i_raddr   (i_addr_nxt[7:4]),
                .i_waddr   (i_addr[7:4]),
                .i_wen     (cache_wen),
                .i_wdata   (cache_wdata),
                .o_rdata   (cache_rdata),
                .o_rdav    (cache_rdav)
        );

        fetch_lookup u_lookup (
                .i_addr        (i_addr),
                .i_mmu_en      (i_mmu_en),
                .i_tlb_entry   (tlb_rdata),
                .i_tlb_valid   (tlb_rdav),
                .i_cache_entry (cache_rdata),
                .i_cache_valid (cache_rdav),
                .o_lookup      (lookup)
        );

        fetch_ctrl u_ctrl (
                .i_clk         (i_clk),
                .i_reset       (i_reset),
                .i_stall       (i_stall),
                .i_clear       (i_clear),
                .i_addr        (i_addr),
                .i_mmu_en      (i_mmu_en),
                .i_cache_en    (i_cache_en),
                .i_table_base  (i_table_base),
                .i_lookup      (lookup),
                .i_ram_rd_data (i_ram_rd_data),
                .i_ram_done    (i_ram_done),
                .o_ram_req     (o_ram_req),
                .o_tlb_wen     (tlb_wen),
                .o_tlb_wdata   (tlb_wdata),
                .o_cache_wen   (cache_wen),
                .o_cache_wdata (cache_wdata),
                .o_refresh     (refresh),
                .o_stall       (o_stall),
                .o_fault       (o_fault),
                .o_rd_data     (o_rd_data),
                .o_fsr         (o_fsr),
                .o_far         (o_far)
        );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
        parameter real PERIOD      = 4.0,        // Clock period in ns.
        parameter int  RESET_CYCLES = 2
) (
        output logic o_clk,
        output logic o_reset
);

        initial
        begin
                o_clk   = 1'b0;
                o_reset = 1'b1;                  // Held from time zero.
                repeat (RESET_CYCLES) @(posedge o_clk);
                #1 o_reset = 1'b0;               // Released just after the edge.
        end

        always #(PERIOD / 2.0) o_clk = ~o_clk;

endmodule

// ==== tb_ram_model.sv ====
`timescale 1ns/1ps

module tb_ram_model
        import ifetch_mmu_pkg::*;
#(
        parameter logic [31:0] TABLE_BASE = 32'h0ff0_0000
) (
        input  logic     i_clk,
        input  logic     i_reset,
        input  ram_req_t i_req,
        output word_t    o_rd_data,
        output logic     o_done          // One cycle per answered read.
);

        word_t       table_mem [4096];   // Filled by the testbench.
        integer      seed;
        logic        busy_q;
        logic [1:0]  wait_q;             // Wait states left.

        initial
        begin
                seed = 32'h8e3d_80f6;
                for (int i = 0; i < 4096; i++)
                        table_mem[i] = '0;   // Invalid descriptor by default.
        end

        // Table region or the address-derived data pattern.
        function automatic word_t read_word(input paddr_t addr);
                if (addr[31:14] == TABLE_BASE[31:14])
                        return table_mem[addr[13:2]];
                return addr ^ 32'h5a5a_0000;
        endfunction

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        busy_q <= 1'b0;
                        wait_q <= '0;
                        o_done <= 1'b0;
                end
                else if (o_done)
                        o_done <= 1'b0;          // Gap cycle after each answer.
                else if (busy_q)
                begin
                        if (wait_q == 2'd0)
                        begin
                                o_done    <= 1'b1;
                                o_rd_data <= read_word(i_req.addr);
                                busy_q    <= 1'b0;
                        end
                        else
                                wait_q <= wait_q - 2'd1;
                end
                else if (i_req.rd_en)
                begin
                        busy_q <= 1'b1;
                        wait_q <= 2'($random(seed) & 3);   // 0 to 3 waits.
                end
        end

endmodule

// ==== tb_ifetch_mmu.sv ====
`timescale 1ns/1ps
`include "ifetch_mmu_defs.svh"

module tb_ifetch_mmu
        import ifetch_mmu_pkg::*;
;

        localparam int          NROWS      = 16;
        localparam logic [31:0] TABLE_BASE = 32'h0ff0_0000;

        // One fetch per row.
        typedef struct {
                string  name;
                vaddr_t va;
                logic   mmu_en;
                logic   cache_en;
                logic   tlb_inv;
                logic   cache_inv;
                logic   hold;            // Core stall in the middle of the miss.
                word_t  exp_word;
                logic   exp_fault;
                int     exp_reads;
        } row_t;

        row_t        rows [NROWS];
        int          nrow;
        int          errors;

        logic        clk, reset;
        vaddr_t      addr_nxt, addr;
        logic        stall, clear, mmu_en, cache_en, tlb_inv, cache_inv;
        word_t       rd_data, ram_rd_data, far;
        logic        dut_stall, fault, ram_done;
        logic [3:0]  fsr;
        ram_req_t    ram_req;

        tb_clk_gen u_clk (.o_clk(clk), .o_reset(reset));

        tb_ram_model #(.TABLE_BASE(TABLE_BASE)) u_ram (
                .i_clk     (clk),
                .i_reset   (reset),
                .i_req     (ram_req),
                .o_rd_data (ram_rd_data),
                .o_done    (ram_done)
        );

        ifetch_mmu_top u_dut (
                .i_clk         (clk),
                .i_reset       (reset),
                .i_addr_nxt    (addr_nxt),
                .i_addr        (addr),
                .i_stall       (stall),
                .i_clear       (clear),
                .i_mmu_en      (mmu_en),
                .i_cache_en    (cache_en),
                .i_tlb_inv     (tlb_inv),
                .i_cache_inv   (cache_inv),
                .i_table_base  (TABLE_BASE),
                .o_rd_data     (rd_data),
                .o_stall       (dut_stall),
                .o_fault       (fault),
                .o_fsr         (fsr),
                .o_far         (far),
                .o_ram_req     (ram_req),
                .i_ram_rd_data (ram_rd_data),
                .i_ram_done    (ram_done)
        );

        // ------------------------------------------------------------------
        // Expected values from the memory rules.
        // ------------------------------------------------------------------
        function automatic word_t expect_word(input vaddr_t va, input logic mmu);
                paddr_t pa;
                pa = va;
                if (mmu)
                        pa = {va[31:20] + 12'd16, va[19:0]};   // Section V to V+16.
                return pa ^ 32'h5a5a_0000;
        endfunction

        function automatic word_t section_desc(input int v, input logic c);
                word_t d;
                d = (v + 16) << 20;
                d[`IFM_DESC_C_BIT] = c;
                d[1:0] = `IFM_DESC_SECTION;
                return d;
        endfunction

        task automatic add_row(input string name, input vaddr_t va, input logic mmu,
                               input logic cen, input logic tinv, input logic cinv,
                               input logic hold, input logic flt, input int reads);
                rows[nrow] = '{name, va, mmu, cen, tinv, cinv, hold,
                               expect_word(va, mmu), flt, reads};
                nrow++;
        endtask

        task automatic check_value(input string name, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
                if (exp !== act)
                begin
                        errors++;
                        $display("[FAIL] %s %s: expected %h, actual %h", name, what, exp, act);
                        $display("Result: FAILED");
                        $fatal(1, "Mismatch in %s.", name);
                end
        endtask

        // Watchdog allows 40 cycles per row plus reset.
        initial
        begin
                #((NROWS * 40 + 20) * 4);
                $display("Fetch did not complete before the time limit.");
                $display("Result: FAILED");
                $fatal(1, "Timeout.");
        end

        // ------------------------------------------------------------------
        // Stimulus.
        // ------------------------------------------------------------------
        initial
        begin
                word_t  got_word;
                logic   got_fault;
                int     reads;
                int     cyc;
                logic   seen;

                stall     = 1'b1;                // Quiet until the first row.
                clear     = 1'b0;
                mmu_en    = 1'b0;
                cache_en  = 1'b0;
                tlb_inv   = 1'b0;
                cache_inv = 1'b0;
                addr      = '0;
                addr_nxt  = '0;
                errors    = 0;
                nrow      = 0;

                //      name           va            mmu   cen   tinv  cinv  hold  flt  reads
                add_row("flat0",       32'h0000_1000, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1);
                add_row("flat1",       32'h0000_2004, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1);
                add_row("flat2",       32'h0030_0008, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1);
                add_row("nc_walk",     32'h0010_0100, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 2);
                add_row("nc_same",     32'h0010_0204, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1);
                add_row("c_walk",      32'h0020_0000, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 2);
                add_row("c_fill",      32'h0020_0040, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 4);
                add_row("c_w1",        32'h0020_0044, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
                add_row("c_w2",        32'h0020_0048, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
                add_row("c_w3",        32'h0020_004c, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 0);
                add_row("sect_fault",  32'h0030_0010, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1);
                add_row("cache_inv",   32'h0020_0044, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 4);
                add_row("tlb_inv",     32'h0010_0300, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 2);
                add_row("stall_fill",  32'h0020_0080, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 5);
                add_row("stall_byp",   32'h0010_0400, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1);
                add_row("flat_cached", 32'h0020_0044, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1);

                @(negedge reset);

                // Section 1 is uncached and section 2 cached. Section 3 stays invalid.
                u_ram.table_mem[1] = section_desc(1, 1'b0);
                u_ram.table_mem[2] = section_desc(2, 1'b1);

                @(posedge clk);
                #1;
                addr_nxt = rows[0].va;

                for (int r = 0; r < NROWS; r++)
                begin
                        // Setup cycle under core stall with controls and pulses applied.
                        stall     = 1'b1;
                        addr      = rows[r].va;
                        addr_nxt  = (r + 1 < NROWS) ? rows[r + 1].va : rows[r].va;
                        mmu_en    = rows[r].mmu_en;
                        cache_en  = rows[r].cache_en;
                        tlb_inv   = rows[r].tlb_inv;
                        cache_inv = rows[r].cache_inv;
                        @(posedge clk);
                        #1;
                        tlb_inv   = 1'b0;
                        cache_inv = 1'b0;
                        stall     = 1'b0;

                        reads = 0;
                        cyc   = 0;
                        seen  = 1'b0;
                        while (!seen)
                        begin
                                @(negedge clk);
                                if (ram_req.rd_en && ram_done)
                                        reads++;                // One answered read.
                                if (!dut_stall && !stall)
                                begin
                                        got_word  = rd_data;
                                        got_fault = fault;
                                        seen      = 1'b1;
                                end
                                @(posedge clk);
                                #1;
                                cyc++;
                                stall = !seen && rows[r].hold && cyc >= 2 && cyc < 6;
                        end

                        check_value(rows[r].name, "fault", 32'(rows[r].exp_fault),
                                    32'(got_fault));
                        if (rows[r].exp_fault)
                        begin
                                // Fault registers load at the completing edge.
                                check_value(rows[r].name, "fsr",
                                            32'(`IFM_FSR_SECTION_FAULT), 32'(fsr));
                                check_value(rows[r].name, "far", rows[r].va, far);
                        end
                        else
                                check_value(rows[r].name, "word", rows[r].exp_word, got_word);
                        check_value(rows[r].name, "reads", rows[r].exp_reads, reads);
                end

                if (errors == 0)
                        $display("Result: PASSED");
                else
                        $display("Result: FAILED");
                $finish;
        end

endmodule

// ==== ifetch_mmu.f ====
+incdir+.
ifetch_mmu_pkg.sv
inv_mem.sv
fetch_lookup.sv
fetch_ctrl.sv
ifetch_mmu_top.sv
tb_clk_gen.sv
tb_ram_model.sv
tb_ifetch_mmu.sv
